//--- Bender.yml
package:
  name: hdmi_loop

sources:
  - verilog/hdmi_pkg.sv
  - verilog/i2c_pkg.sv
  - verilog/i2c_master.sv
  - verilog/hdmi_i2c.sv
  - verilog/hdmi_loop.sv
  - target: test
    files:
      - tests/i2c_slave_model.sv
      - tests/tb_hdmi_loop.sv

//--- sim.f
verilog/hdmi_pkg.sv
verilog/i2c_pkg.sv
verilog/i2c_master.sv
verilog/hdmi_i2c.sv
verilog/hdmi_loop.sv
tests/i2c_slave_model.sv
tests/tb_hdmi_loop.sv

//--- tests/i2c_slave_model.sv
`timescale 1ns/1ns

module i2c_slave_model (
    input  logic scl,
    inout  wire  sda
);

localparam logic [6:0] RX_DEV = 7'h48;   // receiver chip
localparam logic [6:0] TX_DEV = 7'h39;   // transmitter chip

logic        pull_low  = 1'b0;
int          nack_left = 0;             // address bytes still to refuse
logic [22:0] log_q [$];                 // {dev, reg, data} per finished write

assign sda = pull_low ? 1'b0 : 1'bz;    // open drain like the real chips

task automatic force_nacks(input int n);
    nack_left = n;
endtask

task automatic clear_log();
    log_q.delete();
endtask

function automatic int log_size();
    return log_q.size();
endfunction

function automatic logic [22:0] log_at(input int i);
    return log_q[i];
endfunction

// eight bits, msb first, taken on the rising scl
task automatic get_byte(output logic [7:0] b);
    b = 8'h00;
    repeat (8) begin
        @(posedge scl);
        b = {b[6:0], (sda === 1'b0) ? 1'b0 : 1'b1};
    end
endtask

// hold sda low for the ninth clock if acking
task automatic ack_slot(input logic ack);
    @(negedge scl);
    pull_low = ack;
    @(negedge scl);
    pull_low = 1'b0;
endtask

task automatic take_write();
    logic [7:0] addr;
    logic [7:0] ra;
    logic [7:0] d;
    logic       hit;
    get_byte(addr);
    hit = (addr[7:1] == RX_DEV || addr[7:1] == TX_DEV) && !addr[0];
    if (hit && nack_left > 0) begin
        nack_left--;                    // refused address, rest of frame ignored
        hit = 1'b0;
    end
    ack_slot(hit);
    get_byte(ra);
    ack_slot(hit);
    get_byte(d);
    ack_slot(hit);
    do @(posedge sda); while (scl !== 1'b1);   // stop condition
    if (hit)
        log_q.push_back({addr[7:1], ra, d});
endtask

// start = sda falling under a high scl
always begin
    @(negedge sda);
    if (scl === 1'b1)
        take_write();
end

endmodule

//--- tests/tb_hdmi_loop.sv
`timescale 1ns/1ns

module tb_hdmi_loop import hdmi_pkg::*, i2c_pkg::*; ();

localparam int CLK_HALF     = 10;       // 50 MHz sys_clk
localparam int DONE_TIMEOUT = 250000;   // sys_clk cycles for a whole boot

logic        sys_clk;
logic        rst_n;
logic        pix_clk;
video_t      vid_in;
video_t      vid_out;
wire         ddc_sda;
logic        ddc_scl;
logic        hdmi_in_rst_n;
logic        hdmi_out_clk;
logic        hdmi_out_rst_n;
logic        out_hsync;
logic        out_vsync;
logic        out_de;
logic [23:0] out_rgb;
logic        cfg_done;
logic        cfg_err;

int          err_cnt   = 0;
int          check_cnt = 0;
int          test_cnt  = 0;
logic [31:0] lfsr      = 32'h87c15426;
longint      cyc       = 0;
longint      rel_cyc   = 0;             // cycle of reset release
longint      start_cyc [$];
longint      stop_cyc  [$];

always #(CLK_HALF) sys_clk = ~sys_clk;

always @(posedge sys_clk)
    cyc <= cyc + 1;

// bus framing seen on the wires
always @(negedge ddc_sda)
    if (ddc_scl === 1'b1) start_cyc.push_back(cyc);

always @(posedge ddc_sda)
    if (ddc_scl === 1'b1) stop_cyc.push_back(cyc);

pullup (ddc_sda);

hdmi_loop DUT (
    .sys_clk        (sys_clk),
    .rst_n          (rst_n),
    .ddc_scl        (ddc_scl),
    .ddc_sda        (ddc_sda),
    .hdmi_in_clk    (pix_clk),
    .hdmi_in_rst_n  (hdmi_in_rst_n),
    .hdmi_in_hsync  (vid_in.hsync),
    .hdmi_in_vsync  (vid_in.vsync),
    .hdmi_in_de     (vid_in.de),
    .hdmi_in_rgb    (vid_in.rgb),
    .hdmi_out_clk   (hdmi_out_clk),
    .hdmi_out_rst_n (hdmi_out_rst_n),
    .hdmi_out_hsync (out_hsync),
    .hdmi_out_vsync (out_vsync),
    .hdmi_out_de    (out_de),
    .hdmi_out_rgb   (out_rgb),
    .cfg_done       (cfg_done),
    .cfg_err        (cfg_err)
);

i2c_slave_model slave (
    .scl (ddc_scl),
    .sda (ddc_sda)
);

assign vid_out = '{hsync: out_hsync, vsync: out_vsync, de: out_de, rgb: out_rgb};

////////////////////
// helpers
////////////////////

// taps 32 22 2 1 stepped once per bit taken
function automatic logic [31:0] next_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        r    = {r[30:0], fb};
    end
    return r;
endfunction

task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
    check_cnt++;
    if (act !== exp) begin
        err_cnt++;
        $display("Fail %s: got %h expected %h", name, act, exp);
    end
endtask

task automatic report_error(input string what);
    err_cnt++;
    $display("%s", what);
endtask

task automatic finish_test(input string name, input int errs_before);
    test_cnt++;
    $display("test %s finished, %0d errors", name, err_cnt - errs_before);
endtask

// low for 5 cycles in total with end_reset taking the last one
task automatic start_reset(input int nacks);
    @(negedge sys_clk);
    rst_n = 1'b0;
    slave.force_nacks(nacks);
    slave.clear_log();
    repeat (4) @(negedge sys_clk);
endtask

task automatic end_reset();
    @(negedge sys_clk);
    rst_n   = 1'b1;
    rel_cyc = cyc;
    start_cyc.delete();                 // drop edges from the reset itself
    stop_cyc.delete();
endtask

task automatic wait_cfg_done();
    int n;
    n = 0;
    while (cfg_done !== 1'b1 && n < DONE_TIMEOUT) begin
        @(negedge sys_clk);
        n++;
    end
    if (cfg_done !== 1'b1)
        report_error("cfg_done never rose after reset was released");
endtask

// expected traffic is the write entries of the boot table minus the first skip
task automatic compare_log(input int skip);
    logic [22:0] exp_q [$];
    int          n;
    n = 0;
    for (int i = 0; i < CFG_NUM; i++) begin
        if (CFG_TABLE[i].wr.kind == CFG_KIND_WRITE) begin
            if (n >= skip)
                exp_q.push_back({CFG_TABLE[i].wr.dev_addr, CFG_TABLE[i].wr.reg_addr,
                                 CFG_TABLE[i].wr.data});
            n++;
        end
    end
    check_value("slave log size", slave.log_size(), exp_q.size());
    for (int i = 0; i < exp_q.size() && i < slave.log_size(); i++)
        check_value($sformatf("slave log[%0d]", i), slave.log_at(i), exp_q[i]);
endtask

task automatic drive_video(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
        @(negedge sys_clk);
        r       = next_bits(27);
        vid_in  = r[26:0];
        r       = next_bits(1);
        pix_clk = r[0];
        #(CLK_HALF / 2);                // settle time for the unclocked path
        check_value("hdmi_out video", vid_out, vid_in);
        check_value("hdmi_out_clk", hdmi_out_clk, pix_clk);
        check_value("hdmi_in_rst_n", hdmi_in_rst_n, rst_n);
        check_value("hdmi_out_rst_n", hdmi_out_rst_n, rst_n);
    end
endtask

////////////////////
// tests
////////////////////

task automatic test_reset_state();
    int e0;
    e0 = err_cnt;
    start_reset(0);
    check_value("ddc_scl", ddc_scl, 1);
    check_value("ddc_sda", ddc_sda, 1); // released so the pullup wins
    check_value("cfg_done", cfg_done, 0);
    check_value("cfg_err", cfg_err, 0);
    finish_test("reset state", e0);
endtask

task automatic test_video();
    int e0;
    e0 = err_cnt;
    drive_video(8);                     // still in reset here
    end_reset();
    drive_video(8);
    finish_test("video pass-through", e0);
endtask

task automatic test_full_config();
    int e0;
    e0 = err_cnt;
    start_reset(0);
    end_reset();
    wait_cfg_done();
    check_value("cfg_err", cfg_err, 0);
    compare_log(0);
    finish_test("full configuration", e0);
endtask

// gaps measured on the run left by test_full_config
task automatic test_wait_entries();
    int     e0;
    int     n;
    longint need;
    longint gap;
    e0   = err_cnt;
    need = 0;
    n    = 0;
    for (int i = 0; i < CFG_NUM; i++) begin
        if (CFG_TABLE[i].wt.kind == CFG_KIND_WAIT) begin
            need += CFG_TABLE[i].wt.count * WAIT_UNIT;
        end else begin
            if (need > 0) begin
                if (n >= start_cyc.size() || n > stop_cyc.size()) begin
                    report_error($sformatf("no bus START seen for write %0d", n));
                end else begin
                    gap = (n == 0) ? start_cyc[0] - rel_cyc : start_cyc[n] - stop_cyc[n - 1];
                    if (gap < need)
                        report_error($sformatf(
                            "write %0d came %0d cycles after the last event, wait asks %0d",
                            n, gap, need));
                end
            end
            need = 0;
            n++;
        end
    end
    finish_test("wait entries", e0);
endtask

task automatic test_retry();
    int e0;
    e0 = err_cnt;
    start_reset(2);                     // two refusals then the third attempt lands
    end_reset();
    wait_cfg_done();
    check_value("cfg_err", cfg_err, 0);
    compare_log(0);
    finish_test("retry", e0);
endtask

task automatic test_give_up();
    int e0;
    e0 = err_cnt;
    start_reset(RETRY_MAX);             // every attempt of the first write refused
    end_reset();
    wait_cfg_done();
    check_value("cfg_err", cfg_err, 1);
    compare_log(1);
    finish_test("give up", e0);
endtask

initial begin
    sys_clk = 1'b0;
    rst_n   = 1'b0;
    pix_clk = 1'b0;
    vid_in  = '0;

    test_reset_state();
    test_video();
    test_full_config();
    test_wait_entries();
    test_retry();
    test_give_up();

    $display("tests: %0d  checks: %0d  errors: %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
        $display("*** TEST PASSED ***");
    else
        $display("*** TEST FAILED ***");
    $finish;
end

endmodule

//--- verilog/hdmi_i2c.sv
`timescale 1ns/1ns

module hdmi_i2c import i2c_pkg::*; (
    input  logic sys_clk,
    input  logic rst_n,
    input  logic sda_in,
    output logic scl,
    output logic sda_oe,
    output logic cfg_done,      // table finished, held until reset
    output logic cfg_err        // some write abandoned
);

typedef enum logic [2:0] {
    S_FETCH,
    S_WAIT,
    S_START,
    S_XFER,
    S_DONE
} seq_t;

seq_t               state;
logic [IDX_W-1:0]   idx;        // current table entry
logic [WAIT_W-1:0]  wait_cnt;
logic [RETRY_W-1:0] retry_cnt;  // attempts already failed
cfg_word_t          cur;

// master handshake
logic     start;
i2c_req_t req;
logic     busy;
logic     done;
logic     nack;

assign cur = CFG_TABLE[idx[ENTRY_W-1:0]];   // only looked at while idx < CFG_NUM

// write view of the current word
assign req.dev_addr = cur.wr.dev_addr;
assign req.reg_addr = cur.wr.reg_addr;
assign req.data     = cur.wr.data;

assign start = (state == S_START);          // single cycle, master idle here

////////////////////
// sequencer
////////////////////

always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
        state     <= S_FETCH;       // entry 0 read on the first cycle out of reset
        idx       <= '0;
        wait_cnt  <= '0;
        retry_cnt <= '0;
        cfg_done  <= 1'b0;
        cfg_err   <= 1'b0;
    end else begin
        case (state)
            S_FETCH: begin
                if (idx == IDX_W'(CFG_NUM)) begin
                    state    <= S_DONE;
                    cfg_done <= 1'b1;
                end else if (cur.wt.kind == CFG_KIND_WAIT) begin
                    wait_cnt <= WAIT_W'(cur.wt.count) * WAIT_W'(WAIT_UNIT);
                    state    <= S_WAIT;
                end else begin
                    retry_cnt <= '0;
                    state     <= S_START;
                end
            end
            S_WAIT: begin
                // count * WAIT_UNIT cycles spent here
                if (wait_cnt <= WAIT_W'(1)) begin
                    idx   <= idx + 1'b1;
                    state <= S_FETCH;
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end
            S_START: begin
                state <= S_XFER;
            end
            S_XFER: begin
                if (done) begin
                    if (!nack) begin
                        idx   <= idx + 1'b1;
                        state <= S_FETCH;
                    end else if (retry_cnt == RETRY_W'(RETRY_MAX - 1)) begin
                        cfg_err <= 1'b1;        // give up on this entry
                        idx     <= idx + 1'b1;
                        state   <= S_FETCH;
                    end else begin
                        retry_cnt <= retry_cnt + 1'b1;
                        state     <= S_START;   // same entry again
                    end
                end
            end
            S_DONE: ;                           // parked until reset
            default: state <= S_FETCH;
        endcase
    end
end

////////////////////
// bit engine
////////////////////

i2c_master u_master (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .start   (start),
    .req     (req),
    .sda_in  (sda_in),
    .scl     (scl),
    .sda_oe  (sda_oe),
    .busy    (busy),
    .done    (done),
    .nack    (nack)
);

// checks
a_idx_range: assert property (@(posedge sys_clk) disable iff (!rst_n)
    idx <= IDX_W'(CFG_NUM));

// never issue while the engine is still on the bus
a_no_start_busy: assert property (@(posedge sys_clk) disable iff (!rst_n)
    !(start && busy));

a_done_sticky: assert property (@(posedge sys_clk)
    $fell(cfg_done) |-> !$past(rst_n));

endmodule

//--- verilog/hdmi_loop.sv
`timescale 1ns/1ns

module hdmi_loop import hdmi_pkg::*; (
    input  logic        sys_clk,        // 50 MHz
    input  logic        rst_n,

    output logic        ddc_scl,
    inout  wire         ddc_sda,

    input  logic        hdmi_in_clk,
    output logic        hdmi_in_rst_n,
    input  logic        hdmi_in_hsync,
    input  logic        hdmi_in_vsync,
    input  logic        hdmi_in_de,
    input  logic [23:0] hdmi_in_rgb,

    output logic        hdmi_out_clk,
    output logic        hdmi_out_rst_n,
    output logic        hdmi_out_hsync,
    output logic        hdmi_out_vsync,
    output logic        hdmi_out_de,
    output logic [23:0] hdmi_out_rgb,

    output logic        cfg_done,
    output logic        cfg_err
);

video_t vid;            // receiver port, straight to the transmitter
logic   sda_oe;
logic   sda_in;

////////////////////
// video loop
////////////////////

assign vid = '{hsync: hdmi_in_hsync, vsync: hdmi_in_vsync, de: hdmi_in_de, rgb: hdmi_in_rgb};

assign hdmi_out_clk   = hdmi_in_clk;    // rx pixel clock drives the tx too
assign hdmi_out_hsync = vid.hsync;
assign hdmi_out_vsync = vid.vsync;
assign hdmi_out_de    = vid.de;
assign hdmi_out_rgb   = vid.rgb;

// both chips held in reset with the board
assign hdmi_in_rst_n  = rst_n;
assign hdmi_out_rst_n = rst_n;

////////////////////
// ddc config
////////////////////

assign ddc_sda = sda_oe ? 1'b0 : 1'bz;  // open drain, pullup on the board
assign sda_in  = ddc_sda;

hdmi_i2c u_cfg (
    .sys_clk  (sys_clk),
    .rst_n    (rst_n),
    .sda_in   (sda_in),
    .scl      (ddc_scl),
    .sda_oe   (sda_oe),
    .cfg_done (cfg_done),
    .cfg_err  (cfg_err)
);

endmodule

//--- verilog/hdmi_pkg.sv
package hdmi_pkg;

////////////////////
// video bus
////////////////////

// one pixel-clock sample of the parallel video port
// same layout on the receiver and transmitter side
typedef struct packed {
    logic        hsync;     // line sync
    logic        vsync;     // frame sync
    logic        de;        // active video
    logic [23:0] rgb;       // r[23:16] g[15:8] b[7:0]
} video_t;

// 27 bits in total

endpackage

//--- verilog/i2c_master.sv
`timescale 1ns/1ns

module i2c_master import i2c_pkg::*; (
    input  logic     sys_clk,
    input  logic     rst_n,
    input  logic     start,         // one cycle, ignored while busy
    input  i2c_req_t req,
    input  logic     sda_in,
    output logic     scl,
    output logic     sda_oe,        // high pulls sda low
    output logic     busy,
    output logic     done,
    output logic     nack
);

typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_BIT,
    ST_STOP
} state_t;

state_t               state;
logic [SCL_QTR_W-1:0] qcnt;         // cycles within a quarter
logic                 qtick;        // last cycle of a quarter
logic [1:0]           qtr;          // quarter within a slot
logic                 slot_end;
logic [3:0]           bit_cnt;      // 0..7 data, 8 ack
logic [1:0]           byte_cnt;     // dev, reg, data
logic [26:0]          shift;        // outgoing frame, msb first

assign qtick    = (state != ST_IDLE) && (qcnt == SCL_QTR_W'(SCL_QTR - 1));
assign slot_end = qtick && (qtr == 2'd3);
assign busy     = (state != ST_IDLE);

////////////////////
// quarter divider
////////////////////

always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
        qcnt <= '0;
        qtr  <= 2'd0;
    end else if (state == ST_IDLE) begin
        qcnt <= '0;         // every transfer starts on a fresh quarter
        qtr  <= 2'd0;
    end else if (qtick) begin
        qcnt <= '0;
        qtr  <= qtr + 2'd1;
    end else begin
        qcnt <= qcnt + 1'b1;
    end
end

////////////////////
// phase FSM
////////////////////

always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
        state    <= ST_IDLE;
        bit_cnt  <= 4'd0;
        byte_cnt <= 2'd0;
        done     <= 1'b0;
        nack     <= 1'b0;
    end else begin
        done <= 1'b0;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state    <= ST_START;
                    bit_cnt  <= 4'd0;
                    byte_cnt <= 2'd0;
                    nack     <= 1'b0;   // fresh status per transfer
                end
            end
            ST_START: begin
                if (slot_end) state <= ST_BIT;
            end
            ST_BIT: begin
                // ack sampled mid high phase, released line reads 1 on nack
                if (qtick && qtr == 2'd1 && bit_cnt == 4'd8 && sda_in)
                    nack <= 1'b1;
                if (slot_end) begin
                    if (bit_cnt == 4'd8) begin
                        bit_cnt <= 4'd0;
                        if (byte_cnt == 2'd2)
                            state <= ST_STOP;       // all three bytes out
                        else
                            byte_cnt <= byte_cnt + 2'd1;
                    end else begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
            end
            ST_STOP: begin
                if (slot_end) begin
                    state <= ST_IDLE;
                    done  <= 1'b1;      // busy drops on this same cycle
                end
            end
            default: state <= ST_IDLE;
        endcase
    end
end

// frame loaded once, shifted after every bit slot
always_ff @(posedge sys_clk) begin
    if (state == ST_IDLE && start)
        shift <= {req.dev_addr, 1'b0, 1'b1, req.reg_addr, 1'b1, req.data, 1'b1};
    else if (state == ST_BIT && slot_end)
        shift <= {shift[25:0], 1'b1};
end

////////////////////
// line levels
////////////////////

// per quarter: start  H H H L / bit  L H H L / stop  L H H H
always_comb begin
    case (state)
        ST_START: begin
            scl    = (qtr != 2'd3);
            sda_oe = (qtr != 2'd0);     // falls while scl high
        end
        ST_BIT: begin
            scl    = (qtr == 2'd1) || (qtr == 2'd2);
            sda_oe = ~shift[26];        // ack slots carry a 1, so released
        end
        ST_STOP: begin
            scl    = (qtr != 2'd0);
            sda_oe = (qtr < 2'd2);      // rises while scl high
        end
        default: begin
            scl    = 1'b1;              // bus idle
            sda_oe = 1'b0;
        end
    endcase
end

// sda moves under a high scl only to frame the transfer
a_sda_stable: assert property (@(posedge sys_clk) disable iff (!rst_n)
    ($changed(sda_oe) && scl && $past(scl)) |-> (state inside {ST_START, ST_STOP}));

endmodule

//--- verilog/i2c_pkg.sv
package i2c_pkg;

////////////////////
// bus timing
////////////////////

localparam int SCL_QTR   = 125;                 // 100 kHz scl at 50 MHz sys_clk
localparam int SCL_QTR_W = $clog2(SCL_QTR);     // quarter divider width
localparam int WAIT_UNIT = 1024;                // sys_clk cycles per wait unit
localparam int WAIT_W    = 16 + $clog2(WAIT_UNIT);
localparam int RETRY_MAX = 3;                   // attempts per write
localparam int RETRY_W   = $clog2(RETRY_MAX);

////////////////////
// configuration word
////////////////////

localparam logic CFG_KIND_WRITE = 1'b0;
localparam logic CFG_KIND_WAIT  = 1'b1;

// register write to one chip
typedef struct packed {
    logic       kind;       // bit 25 in both views
    logic [1:0] spare;
    logic [6:0] dev_addr;
    logic [7:0] reg_addr;
    logic [7:0] data;
} cfg_wr_t;

// idle time before the next entry
typedef struct packed {
    logic        kind;
    logic [8:0]  spare;
    logic [15:0] count;     // in WAIT_UNIT steps
} cfg_wait_t;

typedef union packed {
    cfg_wr_t   wr;
    cfg_wait_t wt;
} cfg_word_t;               // 26 bits

// one write handed to the bit engine
typedef struct packed {
    logic [6:0] dev_addr;
    logic [7:0] reg_addr;
    logic [7:0] data;
} i2c_req_t;                // 23 bits

function automatic cfg_word_t cfg_write(input logic [6:0] dev, input logic [7:0] ra,
                                        input logic [7:0] d);
    cfg_word_t w;
    w.wr = '{kind: CFG_KIND_WRITE, spare: 2'b00, dev_addr: dev, reg_addr: ra, data: d};
    return w;
endfunction

function automatic cfg_word_t cfg_wait(input logic [15:0] n);
    cfg_word_t w;
    w.wt = '{kind: CFG_KIND_WAIT, spare: 9'd0, count: n};
    return w;
endfunction

////////////////////
// boot table
////////////////////

localparam int ENTRY_W = 3;                     // index into the table
localparam int CFG_NUM = 8;
localparam int IDX_W   = ENTRY_W + 1;           // one more so the end is reachable

localparam cfg_word_t CFG_TABLE [CFG_NUM] = '{
    cfg_wait(16'd4),                    // chips leave reset
    cfg_write(7'h48, 8'h0f, 8'h00),     // rx bank 0
    cfg_write(7'h48, 8'h10, 8'h3c),     // rx port enable
    cfg_write(7'h48, 8'h24, 8'h01),     // rx hpd high
    cfg_wait(16'd2),                    // let the rx settle
    cfg_write(7'h39, 8'h08, 8'h35),     // tx soft reset release
    cfg_write(7'h39, 8'h41, 8'h10),     // tx power up
    cfg_write(7'h39, 8'h98, 8'h03)      // tx output on
};

endpackage
